/* sources.f */
verilog/unpack_pkg.sv
verilog/sync_fifo.sv
verilog/width_acc.sv
verilog/field_unpack.sv
verilog/unpack_top.sv
test/unpack_tb.sv

/* test/unpack_input.txt */
// section header: mode width n_in n_exp, all hex, mode 0 continuous, 1 wrapped
// then n_in input words and n_exp expected fields, ffffffff ends the file

// continuous, width 8, top byte first
0 8 2 8
12345678 9abcdef0
12 34 56 78 9a bc de f0

// continuous, width 5, fields straddle words, one bit left over
0 5 3 13
deadbeef 01234567 89abcdef
1b 1a 16 1b 1d 1b 18 01 04 0d
02 16 0f 02 0d 0b 19 17 17

// continuous, width 16, the old leftover bit must not show up
0 10 2 4
0000ffff 80017ffe
0000 ffff 8001 7ffe

// wrapped, width 12, low byte of each word is padding
1 c 3 6
abc123ff 456789aa fff00055
abc 123 456 789 fff 000

// wrapped, width 16
1 10 2 4
cafebabe 00010002
cafe babe 0001 0002

// continuous, width 1
0 1 1 20
c3a50f81
1 1 0 0 0 0 1 1
1 0 1 0 0 1 0 1
0 0 0 0 1 1 1 1
1 0 0 0 0 0 0 1

// wrapped, width 1
1 1 1 20
7fff0001
0 1 1 1 1 1 1 1
1 1 1 1 1 1 1 1
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 1

// continuous, width 12, long run to fill both queues
0 c 9 18
01234567 89abcdef fedcba98
76543210 0f1e2d3c 4b5a6978
8796a5b4 c3d2e1f0 13579bdf
012 345 678 9ab cde ffe dcb a98
765 432 100 f1e 2d3 c4b 5a6 978
879 6a5 b4c 3d2 e1f 013 579 bdf

// end of sections
ffffffff

/* test/unpack_tb.sv */
`timescale 1ns/1ns

module unpack_tb;

   localparam int          MEM_SIZE    = 1024;
   localparam int          WD_PER_WORD = 50;    // watchdog cycles per input word
   localparam logic [31:0] END_MARK    = 32'hffff_ffff;

   logic                  clk_i;
   logic                  rst_i;
   unpack_pkg::width_t    cfg_width_i;
   logic                  cfg_wrap_i;
   logic                  in_write_i;
   unpack_pkg::in_word_t  in_data_i;
   logic                  in_ready_o;
   logic                  out_read_i;
   logic                  out_ready_o;
   unpack_pkg::out_word_t out_data_o;

   logic [31:0] vec [MEM_SIZE];  // sections from the data file
   logic [31:0] lfsr;
   int          wd_cycles;
   int          total_in;

   unpack_top i_dut (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .cfg_width_i(cfg_width_i),
      .cfg_wrap_i (cfg_wrap_i),
      .in_write_i (in_write_i),
      .in_data_i  (in_data_i),
      .in_ready_o (in_ready_o),
      .out_read_i (out_read_i),
      .out_ready_o(out_ready_o),
      .out_data_o (out_data_o)
   );

   initial clk_i = 1'b0;
   always #2 clk_i = ~clk_i;

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic next_random_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         $display("Verification failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // walks the headers once for totals and sanity
   task automatic scan_vectors();
      int   ptr;
      int   sections;
      logic done;
      ptr       = 0;
      sections  = 0;
      done      = 1'b0;
      total_in  = 0;
      while (!done) begin
         if (ptr + 4 > MEM_SIZE || $isunknown(vec[ptr])) begin
            stop_run("test data file has no end marker");
         end else if (vec[ptr] == END_MARK) begin
            done = 1'b1;
         end else begin
            if (vec[ptr] > 1 || vec[ptr+1] < 1 || vec[ptr+1] > unpack_pkg::OUT_W) begin
               stop_run($sformatf("bad section header at entry %0d of the data file", ptr));
            end
            total_in  += int'(vec[ptr+2]);
            ptr       += 4 + int'(vec[ptr+2]) + int'(vec[ptr+3]);
            sections++;
         end
      end
      if (sections == 0) begin
         stop_run("test data file holds no sections");
      end
   endtask

   task automatic run_section(input int base, input int sec);
      logic mode;
      int   width;
      int   n_in;
      int   n_exp;
      int   i;
      int   k;
      logic capture;
      logic rd_go;
      logic wr_go;
      mode    = vec[base][0];
      width   = int'(vec[base+1]);
      n_in    = int'(vec[base+2]);
      n_exp   = int'(vec[base+3]);
      i       = 0;
      k       = 0;
      capture = 1'b0;

      @(posedge clk_i);
      rst_i       <= 1'b1;
      cfg_width_i <= unpack_pkg::width_t'(width);
      cfg_wrap_i  <= mode;
      in_write_i  <= 1'b0;
      out_read_i  <= 1'b0;
      repeat (2) @(posedge clk_i);
      rst_i <= 1'b0;

      // nothing may come out before the first push
      repeat (3) begin
         @(negedge clk_i);
         check_value(out_ready_o, 32'd0, $sformatf("section %0d out_ready_o before input", sec));
         check_value(in_ready_o, 32'd1, $sformatf("section %0d in_ready_o after reset", sec));
      end

      while (k < n_exp || i < n_in) begin
         @(negedge clk_i);
         if (capture) begin
            check_value(out_data_o, vec[base+4+n_in+k],
                        $sformatf("section %0d field %0d", sec, k));
            k++;
         end
         capture = out_read_i;  // read in flight lands at the next edge
         rd_go   = 1'b0;
         wr_go   = 1'b0;
         if (!out_read_i && out_ready_o && k < n_exp) begin
            rd_go = next_random_bit();
         end
         if (!in_write_i && in_ready_o && i < n_in) begin
            wr_go = !next_random_bit();  // set bit holds the word back
         end
         @(posedge clk_i);
         out_read_i <= rd_go;
         in_write_i <= wr_go;
         if (wr_go) begin
            in_data_i <= vec[base+4+i];
            i++;
         end
      end
      @(posedge clk_i);
      in_write_i <= 1'b0;
      out_read_i <= 1'b0;

      // no extra field, leftover bits stay inside
      repeat (8) begin
         @(negedge clk_i);
         check_value(out_ready_o, 32'd0, $sformatf("section %0d extra field", sec));
      end
   endtask

   initial begin
      wait (wd_cycles > 0);
      repeat (wd_cycles) @(posedge clk_i);
      stop_run($sformatf("output stalled, run not done after %0d cycles", wd_cycles));
   end

   initial begin
      int base;
      int sec;
      rst_i       = 1'b1;
      cfg_width_i = unpack_pkg::width_t'(8);
      cfg_wrap_i  = 1'b0;
      in_write_i  = 1'b0;
      in_data_i   = '0;
      out_read_i  = 1'b0;
      lfsr        = 32'hea68_0a5a;
      wd_cycles   = 0;

      $readmemh("test/unpack_input.txt", vec);
      scan_vectors();
      wd_cycles = (total_in + 1) * WD_PER_WORD;

      base = 0;
      sec  = 0;
      while (vec[base] != END_MARK) begin
         run_section(base, sec);
         base += 4 + int'(vec[base+2]) + int'(vec[base+3]);
         sec++;
      end

      $display("Verification passed");
      $finish;
   end

endmodule

/* verilog/field_unpack.sv */
`timescale 1ns/1ns

module field_unpack (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic [unpack_pkg::WIDTH_W-1:0] width_i,
   input  logic                           wrap_i,
   input  unpack_pkg::in_word_t           src_data_i,
   input  logic                           src_ready_i,
   output logic                           src_read_o,
   output unpack_pkg::out_word_t          dst_data_o,
   output logic                           dst_write_o,
   input  logic                           dst_ready_i
);

   unpack_pkg::dbl_t      data_q;       // unread bits, left aligned
   unpack_pkg::dbl_t      data_d;
   logic [1:0]            pcnt_q;
   logic [1:0]            pcnt_d;
   unpack_pkg::width_t    lead_q;       // leftover bits ahead of the new word
   unpack_pkg::width_t    lead_d;

   unpack_pkg::acc_t      acc;
   unpack_pkg::acc_t      acc_nxt;
   logic                  acc_clr;
   logic                  acc_en;

   unpack_pkg::acc_t      limit;        // bits held after the last load
   unpack_pkg::acc_t      load_shift;
   unpack_pkg::acc_t      pad_shift;
   unpack_pkg::width_t    field_shift;
   unpack_pkg::out_word_t top_bits;
   logic                  fits;

   // leftover count plus one whole word
   assign limit      = unpack_pkg::acc_t'(unpack_pkg::IN_W) + unpack_pkg::acc_t'(lead_q);
   // places the new word right under the leftover bits
   assign load_shift = unpack_pkg::acc_t'(unpack_pkg::IN_W) - unpack_pkg::acc_t'(lead_q);
   assign pad_shift  = unpack_pkg::acc_t'(unpack_pkg::IN_W) - acc;  // wrapped mode only

   assign fits = (acc_nxt <= limit);

   // top field, right aligned with zero upper bits
   assign top_bits    = data_q[unpack_pkg::DBL_W-1 -: unpack_pkg::OUT_W];
   assign field_shift = unpack_pkg::width_t'(unpack_pkg::OUT_W) - width_i;
   assign dst_data_o  = top_bits >> field_shift;

   always_comb begin
      pcnt_d      = pcnt_q + 2'd1;
      data_d      = data_q;
      lead_d      = lead_q;
      src_read_o  = 1'b0;
      dst_write_o = 1'b0;
      acc_en      = 1'b0;
      acc_clr     = 1'b0;

      case (pcnt_q)
         unpack_pkg::PH_WAIT: begin
            if (src_ready_i) begin
               src_read_o = 1'b1;
            end else begin
               pcnt_d = pcnt_q;  // nothing queued yet
            end
         end
         unpack_pkg::PH_LOAD: begin
            data_d = data_q | (unpack_pkg::dbl_t'(src_data_i) << load_shift);
         end
         unpack_pkg::PH_EMIT: begin
            pcnt_d = pcnt_q;
            if (fits) begin
               if (dst_ready_i) begin
                  dst_write_o = 1'b1;
                  acc_en      = 1'b1;
                  data_d      = data_q << width_i;
               end
            end else begin
               acc_clr = 1'b1;
               if (wrap_i) begin
                  data_d = data_q << pad_shift;  // padding dropped
                  lead_d = '0;
               end else begin
                  // straddling field is finished after the next load
                  lead_d = unpack_pkg::width_t'(limit - acc);
               end
               if (src_ready_i) begin
                  src_read_o = 1'b1;
                  pcnt_d     = unpack_pkg::PH_LOAD;
               end else begin
                  pcnt_d = unpack_pkg::PH_WAIT;
               end
            end
         end
         default: begin
            pcnt_d = unpack_pkg::PH_WAIT;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pcnt_q <= unpack_pkg::PH_WAIT;
         data_q <= '0;
         lead_q <= '0;
      end else begin
         pcnt_q <= pcnt_d;
         data_q <= data_d;
         lead_q <= lead_d;
      end
   end

   // bits taken since the last load
   width_acc i_acc (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .clear_i  (acc_clr),
      .en_i     (acc_en),
      .incr_i   (width_i),
      .sum_o    (acc),
      .sum_nxt_o(acc_nxt)
   );

   a_width_range : assert property (
      @(posedge clk_i) disable iff (rst_i)
      (width_i >= unpack_pkg::width_t'(1)) &&
      (width_i <= unpack_pkg::width_t'(unpack_pkg::OUT_W))
   ) else $error("field width %0d out of range", width_i);

endmodule

/* verilog/sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
   parameter type entry_t = logic,
   parameter int  DEPTH   = 8
) (
   input  logic   clk_i,
   input  logic   rst_i,
   input  logic   wr_i,
   input  entry_t wr_data_i,
   input  logic   rd_i,
   output entry_t rd_data_o,
   output logic   not_full_o,
   output logic   not_empty_o
);

   typedef logic [$clog2(DEPTH)-1:0] ptr_t;
   typedef logic [$clog2(DEPTH):0]   cnt_t;

   entry_t mem [DEPTH];
   ptr_t   wr_ptr;
   ptr_t   rd_ptr;
   cnt_t   count;
   logic   do_wr;
   logic   do_rd;

   assign not_full_o  = (count != cnt_t'(DEPTH));
   assign not_empty_o = (count != '0);

   assign do_wr = wr_i && not_full_o;
   assign do_rd = rd_i && not_empty_o;

   // pointers wrap on their own at a power-of-two depth
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + ptr_t'(1);
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + ptr_t'(1);
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + cnt_t'(1);
            2'b01:   count <= count - cnt_t'(1);
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   // read data follows the read pulse by one cycle
   always_ff @(posedge clk_i) begin
      if (do_rd) begin
         rd_data_o <= mem[rd_ptr];
      end
   end

   a_no_write_full : assert property (
      @(posedge clk_i) disable iff (rst_i)
      wr_i |-> not_full_o
   ) else $error("write into a full queue");

   a_no_read_empty : assert property (
      @(posedge clk_i) disable iff (rst_i)
      rd_i |-> not_empty_o
   ) else $error("read from an empty queue");

endmodule

/* verilog/unpack_pkg.sv */
package unpack_pkg;

   localparam int IN_W      = 32;                 // input word width
   localparam int OUT_W     = 16;                 // widest field and output word
   localparam int WIDTH_W   = $clog2(OUT_W) + 1;  // holds OUT_W itself
   localparam int ACC_W     = WIDTH_W + 1;        // next sum may pass IN_W
   localparam int DBL_W     = 2 * IN_W;           // double-word shift register

   localparam int IN_DEPTH  = 8;
   localparam int OUT_DEPTH = 8;

   // phase counter codes of the unpacker
   localparam logic [1:0] PH_WAIT = 2'd0;  // wait for input, read it
   localparam logic [1:0] PH_LOAD = 2'd1;  // word lands in the register
   localparam logic [1:0] PH_EMIT = 2'd2;  // present fields

   typedef logic [IN_W-1:0]    in_word_t;
   typedef logic [OUT_W-1:0]   out_word_t;

   typedef logic [WIDTH_W-1:0] width_t;
   typedef logic [ACC_W-1:0]   acc_t;
   typedef logic [DBL_W-1:0]   dbl_t;

endpackage

/* verilog/unpack_top.sv */
`timescale 1ns/1ns

module unpack_top (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic [unpack_pkg::WIDTH_W-1:0] cfg_width_i,
   input  logic                           cfg_wrap_i,
   input  logic                           in_write_i,
   input  unpack_pkg::in_word_t           in_data_i,
   output logic                           in_ready_o,
   input  logic                           out_read_i,
   output logic                           out_ready_o,
   output unpack_pkg::out_word_t          out_data_o
);

   logic                  src_ready;
   logic                  src_read;
   unpack_pkg::in_word_t  src_data;
   logic                  dst_ready;
   logic                  dst_write;
   unpack_pkg::out_word_t dst_data;

   sync_fifo #(
      .entry_t(unpack_pkg::in_word_t),
      .DEPTH  (unpack_pkg::IN_DEPTH)
   ) i_in_fifo (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .wr_i       (in_write_i),
      .wr_data_i  (in_data_i),
      .rd_i       (src_read),
      .rd_data_o  (src_data),
      .not_full_o (in_ready_o),
      .not_empty_o(src_ready)
   );

   field_unpack i_unpack (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .width_i    (cfg_width_i),
      .wrap_i     (cfg_wrap_i),
      .src_data_i (src_data),
      .src_ready_i(src_ready),
      .src_read_o (src_read),
      .dst_data_o (dst_data),
      .dst_write_o(dst_write),
      .dst_ready_i(dst_ready)
   );

   sync_fifo #(
      .entry_t(unpack_pkg::out_word_t),
      .DEPTH  (unpack_pkg::OUT_DEPTH)
   ) i_out_fifo (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .wr_i       (dst_write),
      .wr_data_i  (dst_data),
      .rd_i       (out_read_i),
      .rd_data_o  (out_data_o),
      .not_full_o (dst_ready),
      .not_empty_o(out_ready_o)
   );

endmodule

/* verilog/width_acc.sv */
`timescale 1ns/1ns

module width_acc (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           clear_i,
   input  logic                           en_i,
   input  logic [unpack_pkg::WIDTH_W-1:0] incr_i,
   output logic [unpack_pkg::ACC_W-1:0]   sum_o,
   output logic [unpack_pkg::ACC_W-1:0]   sum_nxt_o
);

   // sum if this increment were taken, lets the caller look ahead
   assign sum_nxt_o = sum_o + unpack_pkg::acc_t'(incr_i);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sum_o <= '0;
      end else if (clear_i) begin  // clear wins over enable
         sum_o <= '0;
      end else if (en_i) begin
         sum_o <= sum_nxt_o;
      end
   end

endmodule
